// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILE_LIST ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/alu_stage.sv ====
`timescale 1ns/100ps

module alu_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::ex_stage_t ex,
    output rv_core_pkg::wb_stage_t wb
);

    rv_core_pkg::word_t result;
    logic [4:0]         shamt;      // only the low 5 bits shift on rv32

    assign shamt = ex.operand_b[4:0];

    always_comb begin
        result = '0;
        case (ex.op)
            rv_core_pkg::ALU_ADD:  result = ex.operand_a + ex.operand_b;
            rv_core_pkg::ALU_SUB:  result = ex.operand_a - ex.operand_b;
            rv_core_pkg::ALU_SLL:  result = ex.operand_a << shamt;
            rv_core_pkg::ALU_SLT: begin
                // signed compare
                result = {31'b0, $signed(ex.operand_a) < $signed(ex.operand_b)};
            end
            rv_core_pkg::ALU_SLTU: begin
                result = {31'b0, ex.operand_a < ex.operand_b};
            end
            rv_core_pkg::ALU_XOR:  result = ex.operand_a ^ ex.operand_b;
            rv_core_pkg::ALU_SRL:  result = ex.operand_a >> shamt;
            rv_core_pkg::ALU_SRA:  result = $signed(ex.operand_a) >>> shamt;  // sign fills
            rv_core_pkg::ALU_OR:   result = ex.operand_a | ex.operand_b;
            rv_core_pkg::ALU_AND:  result = ex.operand_a & ex.operand_b;
            default:               result = '0;  // codes 10..15 unused
        endcase
    end

    // writeback stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            wb.rd     <= ex.rd;
            wb.result <= result;
        end
    end

endmodule

// ==== rtl/apb_port.sv ====
`timescale 1ns/100ps

module apb_port (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::apb_req_t apb_req,
    output rv_core_pkg::word_t    prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  issue_valid,
    output rv_core_pkg::word_t    issue_instr,
    input  logic                  illegal,      // from decoder, same cycle
    input  logic                  pipe_busy,    // ex or wb stage holds an instruction
    output rv_core_pkg::reg_idx_t dbg_idx,
    input  rv_core_pkg::word_t    dbg_data
);

    typedef enum logic {
        apb_idle,
        apb_read_wait
    } apb_state_t;

    apb_state_t            state;
    apb_state_t            state_next;
    logic                  access;        // access phase of any transfer
    logic                  write_access;
    logic                  read_access;
    logic                  issue_hit;
    logic                  reg_hit;       // address falls in the register window
    rv_core_pkg::apb_addr_t reg_offset;

    assign access       = apb_req.psel & apb_req.penable;
    assign write_access = access & apb_req.pwrite;
    assign read_access  = access & ~apb_req.pwrite;

    assign issue_hit  = apb_req.paddr == rv_core_pkg::ISSUE_ADDR;
    assign reg_offset = apb_req.paddr - rv_core_pkg::REG_BASE_ADDR;
    assign reg_hit    = (apb_req.paddr >= rv_core_pkg::REG_BASE_ADDR)
                      && (int'(reg_offset) < rv_core_pkg::REG_WINDOW_BYTES)
                      && (apb_req.paddr[1:0] == 2'b00);  // word aligned only

    // instruction goes to the decoder during the single write access cycle
    assign issue_valid = write_access & issue_hit;
    assign issue_instr = apb_req.pwdata;
    assign dbg_idx     = reg_offset[$bits(rv_core_pkg::reg_idx_t)+1:2];

    // a register read waits here until the pipeline has drained
    always_comb begin
        state_next = state;
        case (state)
            apb_idle: begin
                // setup phase of a register read
                if (apb_req.psel && !apb_req.penable && !apb_req.pwrite && reg_hit) begin
                    state_next = apb_read_wait;
                end
            end
            apb_read_wait: begin
                if (apb_req.penable && !pipe_busy) begin
                    state_next = apb_idle;  // read completes on this edge
                end
            end
            default: state_next = apb_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= apb_idle;
        end else begin
            state <= state_next;
        end
    end

    // writes never wait, unmapped reads finish at once
    assign pready = write_access
                  | (read_access & ~reg_hit)
                  | (read_access & (state == apb_read_wait) & ~pipe_busy);

    // bad instruction or any write outside the issue address
    assign pslverr = write_access & (issue_hit ? illegal : 1'b1);

    assign prdata = (read_access && reg_hit && state == apb_read_wait) ? dbg_data : '0;

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  rv_core_pkg::word_t     issue_instr,
    output logic                   illegal,
    output rv_core_pkg::reg_idx_t  rs1_idx,
    output rv_core_pkg::reg_idx_t  rs2_idx,
    input  rv_core_pkg::word_t     rs1_data,
    input  rv_core_pkg::word_t     rs2_data,
    input  rv_core_pkg::wb_stage_t wb,         // predecessor still in flight
    output rv_core_pkg::ex_stage_t ex
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv_core_pkg::word_t   imm;          // sign extended I-type immediate
    logic                 fwd_rs1;
    logic                 fwd_rs2;
    rv_core_pkg::word_t   rs1_value;
    rv_core_pkg::word_t   rs2_value;
    rv_core_pkg::alu_op_t op;
    rv_core_pkg::word_t   operand_b;
    logic                 bad_instr;

    assign opcode  = issue_instr[6:0];
    assign funct3  = issue_instr[14:12];
    assign funct7  = issue_instr[31:25];
    assign rs1_idx = issue_instr[19:15];
    assign rs2_idx = issue_instr[24:20];
    assign imm     = {{(rv_core_pkg::XLEN-12){issue_instr[31]}}, issue_instr[31:20]};

    // issues are two cycles apart, so only the wb stage can hold a pending rd
    assign fwd_rs1 = wb.valid && (wb.rd == rs1_idx) && (rs1_idx != '0);
    assign fwd_rs2 = wb.valid && (wb.rd == rs2_idx) && (rs2_idx != '0);

    assign rs1_value = fwd_rs1 ? wb.result : rs1_data;
    assign rs2_value = fwd_rs2 ? wb.result : rs2_data;

    // funct3 picks the operation, funct7[5] the SUB/SRA variant
    always_comb begin
        op = rv_core_pkg::ALU_ADD;
        case (funct3)
            rv_core_pkg::FUNCT3_ADD: begin
                // ADDI has immediate bits in funct7 and never subtracts
                if (opcode == rv_core_pkg::OPCODE_OP && funct7[5]) begin
                    op = rv_core_pkg::ALU_SUB;
                end
            end
            rv_core_pkg::FUNCT3_SLL:  op = rv_core_pkg::ALU_SLL;
            rv_core_pkg::FUNCT3_SLT:  op = rv_core_pkg::ALU_SLT;
            rv_core_pkg::FUNCT3_SLTU: op = rv_core_pkg::ALU_SLTU;
            rv_core_pkg::FUNCT3_XOR:  op = rv_core_pkg::ALU_XOR;
            rv_core_pkg::FUNCT3_SR:   op = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            rv_core_pkg::FUNCT3_OR:   op = rv_core_pkg::ALU_OR;
            rv_core_pkg::FUNCT3_AND:  op = rv_core_pkg::ALU_AND;
            default:                  op = rv_core_pkg::ALU_ADD;
        endcase
    end

    // operand b source and legality check
    always_comb begin
        bad_instr = 1'b0;
        operand_b = rs2_value;
        case (opcode)
            rv_core_pkg::OPCODE_OP_IMM: begin
                operand_b = imm;  // shamt sits in imm[4:0], the alu reads only those
                if (funct3 == rv_core_pkg::FUNCT3_SLL) begin
                    bad_instr = funct7 != rv_core_pkg::FUNCT7_BASE;
                end else if (funct3 == rv_core_pkg::FUNCT3_SR) begin
                    bad_instr = (funct7 != rv_core_pkg::FUNCT7_BASE)
                              && (funct7 != rv_core_pkg::FUNCT7_ALT);
                end
            end
            rv_core_pkg::OPCODE_OP: begin
                // alternate funct7 only for SUB and SRA
                bad_instr = !((funct7 == rv_core_pkg::FUNCT7_BASE)
                           || (funct7 == rv_core_pkg::FUNCT7_ALT
                               && (funct3 == rv_core_pkg::FUNCT3_ADD
                                   || funct3 == rv_core_pkg::FUNCT3_SR)));
            end
            default: bad_instr = 1'b1;  // dropped or unknown opcode
        endcase
    end

    assign illegal = issue_valid & bad_instr;

    // execute stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= issue_valid & ~bad_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ex.op        <= op;
            ex.operand_a <= rs1_value;
            ex.operand_b <= operand_b;
            ex.rd        <= issue_instr[11:7];
        end
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::wb_stage_t wb,
    input  rv_core_pkg::reg_idx_t  rs1_idx,
    input  rv_core_pkg::reg_idx_t  rs2_idx,
    input  rv_core_pkg::reg_idx_t  dbg_idx,   // apb read port
    output rv_core_pkg::word_t     rs1_data,
    output rv_core_pkg::word_t     rs2_data,
    output rv_core_pkg::word_t     dbg_data
);

    // x0 has no storage
    rv_core_pkg::word_t regs [1:rv_core_pkg::REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < rv_core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // x0 reads zero
    function automatic rv_core_pkg::word_t read_reg(rv_core_pkg::reg_idx_t idx);
        rv_core_pkg::word_t value;
        value = '0;
        if (idx != '0) begin
            value = regs[idx];
        end
        return value;
    endfunction

    // asynchronous read, follows every write to regs
    always_comb begin
        rs1_data = read_reg(rs1_idx);
        rs2_data = read_reg(rs2_idx);
        dbg_data = read_reg(dbg_idx);
    end

endmodule

// ==== rtl/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    // widths with a meaning of their own
    typedef logic [XLEN-1:0]              word_t;     // register or data value
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;  // x0..x31
    typedef logic [3:0]                   alu_op_t;
    typedef logic [11:0]                  apb_addr_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // rv32i major opcodes that are kept
    localparam logic [6:0] OPCODE_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPCODE_OP     = 7'b011_0011;

    // funct3 field, shared by OP and OP-IMM
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;  // also SUB
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;  // SRL or SRA
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;  // SUB, SRA, SRAI

    // apb address map
    localparam apb_addr_t ISSUE_ADDR       = 12'h000;
    localparam apb_addr_t REG_BASE_ADDR    = 12'h080;  // xn at base + 4n
    localparam int        REG_WINDOW_BYTES = 4 * REG_COUNT;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    // decode -> alu
    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        word_t    operand_a;
        word_t    operand_b;
        reg_idx_t rd;
    } ex_stage_t;

    // alu -> register file, also the forwarding source
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
    } wb_stage_t;

endpackage

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/100ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::apb_req_t apb_req,
    output rv_core_pkg::word_t    prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic                   issue_valid;
    rv_core_pkg::word_t     issue_instr;
    logic                   illegal;
    logic                   pipe_busy;
    rv_core_pkg::reg_idx_t  rs1_idx;
    rv_core_pkg::reg_idx_t  rs2_idx;
    rv_core_pkg::reg_idx_t  dbg_idx;
    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;
    rv_core_pkg::word_t     dbg_data;
    rv_core_pkg::ex_stage_t ex;
    rv_core_pkg::wb_stage_t wb;

    // register reads stall until both stages are empty
    assign pipe_busy = ex.valid | wb.valid;

    apb_port apb_port_i (
        .clk         (clk),
        .reset       (reset),
        .apb_req     (apb_req),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .illegal     (illegal),
        .pipe_busy   (pipe_busy),
        .dbg_idx     (dbg_idx),
        .dbg_data    (dbg_data)
    );

    instr_decoder instr_decoder_i (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .illegal     (illegal),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb          (wb),          // forwarding source
        .ex          (ex)
    );

    alu_stage alu_stage_i (
        .clk   (clk),
        .reset (reset),
        .ex    (ex),
        .wb    (wb)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .wb       (wb),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .dbg_idx  (dbg_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

endmodule

// ==== tb.f ====
rtl/rv_core_pkg.sv
rtl/apb_port.sv
rtl/instr_decoder.sv
rtl/alu_stage.sv
rtl/register_file.sv
rtl/rv_core_top.sv
test/rv_core_asserts.sv
test/tb_rv_core.sv

// ==== test/rv_core_asserts.sv ====
`timescale 1ns/100ps

module rv_core_asserts (
    input logic                  clk,
    input logic                  reset,
    input rv_core_pkg::apb_req_t apb_req,
    input logic                  pready,
    input logic                  pslverr,
    input logic                  illegal,
    input logic                  ex_valid,
    input rv_core_pkg::reg_idx_t rs1_idx,
    input rv_core_pkg::reg_idx_t rs2_idx,
    input rv_core_pkg::reg_idx_t dbg_idx,
    input rv_core_pkg::word_t    rs1_data,
    input rv_core_pkg::word_t    rs2_data,
    input rv_core_pkg::word_t    dbg_data
);

    // error response only on a completing access cycle
    err_on_completion: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (apb_req.psel && apb_req.penable && pready))
        else $error("pslverr outside a completing access cycle");

    write_no_wait: assert property (@(posedge clk) disable iff (reset)
        (apb_req.psel && apb_req.penable && apb_req.pwrite) |-> pready)
        else $error("write access cycle with pready low");

    // a rejected instruction never reaches execute
    illegal_not_issued: assert property (@(posedge clk) disable iff (reset)
        illegal |=> !ex_valid)
        else $error("illegal instruction loaded into the ex stage");

    x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (rs1_idx != '0 || rs1_data == '0) && (rs2_idx != '0 || rs2_data == '0)
        && (dbg_idx != '0 || dbg_data == '0))
        else $error("x0 read back nonzero");

endmodule

bind rv_core_top rv_core_asserts rv_core_asserts_i (
    .clk      (clk),
    .reset    (reset),
    .apb_req  (apb_req),
    .pready   (pready),
    .pslverr  (pslverr),
    .illegal  (illegal),
    .ex_valid (ex.valid),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .dbg_idx  (dbg_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_data (dbg_data)
);

// ==== test/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

    localparam int CLK_PERIOD_NS = 4;
    localparam logic [31:0] LFSR_SEED = 32'h4b55_0d68;

    // apb transfers per test for sizing the watchdog
    localparam int XFERS_RESET   = 32;
    localparam int XFERS_OP_IMM  = 34;
    localparam int XFERS_OP      = 39;
    localparam int XFERS_FORWARD = 12;
    localparam int XFERS_ZERO    = 11;
    localparam int XFERS_ERRORS  = 39;
    localparam int XFERS_RANDOM  = 92;
    localparam int XFERS_TOTAL   = XFERS_RESET + XFERS_OP_IMM + XFERS_OP + XFERS_FORWARD
                                 + XFERS_ZERO + XFERS_ERRORS + XFERS_RANDOM;
    localparam int CYCLES_PER_XFER = 4;  // setup, access, up to two drain cycles
    localparam int WATCHDOG_NS     = XFERS_TOTAL * CYCLES_PER_XFER * CLK_PERIOD_NS * 3;

    logic                  clk;
    logic                  reset;
    rv_core_pkg::apb_req_t apb_req;
    rv_core_pkg::word_t    prdata;
    logic                  pready;
    logic                  pslverr;

    rv_core_pkg::word_t model_regs [rv_core_pkg::REG_COUNT];  // expected register file
    logic [31:0]        lfsr;
    int                 data_errors;      // wrong register values
    int                 response_errors;  // wrong pslverr

    rv_core_top rv_core_top_i (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};  // one step per bit
        end
        return value;
    endfunction

    function automatic rv_core_pkg::word_t encode_imm(logic [11:0] imm,
            rv_core_pkg::reg_idx_t rs1, logic [2:0] funct3, rv_core_pkg::reg_idx_t rd);
        return {imm, rs1, funct3, rd, rv_core_pkg::OPCODE_OP_IMM};
    endfunction

    function automatic rv_core_pkg::word_t encode_reg(logic [6:0] funct7,
            rv_core_pkg::reg_idx_t rs2, rv_core_pkg::reg_idx_t rs1, logic [2:0] funct3,
            rv_core_pkg::reg_idx_t rd);
        return {funct7, rs2, rs1, funct3, rd, rv_core_pkg::OPCODE_OP};
    endfunction

    // writes the rv32i result of a legal OP or OP-IMM instruction into the model
    function automatic void model_apply(rv_core_pkg::word_t instr);
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        rv_core_pkg::word_t r;
        logic               alt;   // instr bit 30
        logic [4:0]         sh;
        a   = model_regs[instr[19:15]];
        alt = instr[30];
        if (instr[6:0] == rv_core_pkg::OPCODE_OP_IMM) begin
            b   = {{20{instr[31]}}, instr[31:20]};
            alt = alt && (instr[14:12] == 3'b101);  // addi has no subtract form
        end else begin
            b = model_regs[instr[24:20]];
        end
        sh = b[4:0];
        case (instr[14:12])
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};  // signed
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: r = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        if (instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = r;
        end
    endfunction

    // starts and ends on a falling edge, so back to back transfers are two cycles apart
    task automatic apb_transfer(input logic write, input rv_core_pkg::apb_addr_t addr,
            input rv_core_pkg::word_t wdata, output rv_core_pkg::word_t rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;  // response settles
        while (!pready) begin
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);  // completion edge has passed
        apb_req = '0;
    endtask

    task automatic apb_write(input rv_core_pkg::apb_addr_t addr, input rv_core_pkg::word_t data,
            output logic err);
        rv_core_pkg::word_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input rv_core_pkg::apb_addr_t addr, output rv_core_pkg::word_t data,
            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic check_err(input logic got, input logic expected);
        assert (got == expected) else begin
            response_errors++;
            $display("error %0t: pslverr is %b, expected %b", $time, got, expected);
        end
    endtask

    task automatic issue(input rv_core_pkg::word_t instr, input logic legal);
        logic err;
        apb_write(rv_core_pkg::ISSUE_ADDR, instr, err);
        check_err(err, !legal);
        if (legal) begin
            model_apply(instr);
        end
    endtask

    task automatic check_reg(input rv_core_pkg::reg_idx_t idx);
        rv_core_pkg::word_t data;
        logic               err;
        apb_read(rv_core_pkg::REG_BASE_ADDR + 12'(4 * idx), data, err);
        check_err(err, 1'b0);
        assert (data == model_regs[idx]) else begin
            data_errors++;
            $display("error %0t: prdata for x%0d is %h, expected %h",
                     $time, idx, data, model_regs[idx]);
        end
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < rv_core_pkg::REG_COUNT; i++) begin
            check_reg(5'(i));
        end
    endtask

    // builds any 32 bit value from 11 + 11 + 10 bit pieces
    task automatic load_reg(input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::word_t value);
        issue(encode_imm({1'b0, value[31:21]}, 5'd0, rv_core_pkg::FUNCT3_ADD, rd), 1'b1);
        issue(encode_imm(12'd11, rd, rv_core_pkg::FUNCT3_SLL, rd), 1'b1);
        issue(encode_imm({1'b0, value[20:10]}, rd, rv_core_pkg::FUNCT3_OR, rd), 1'b1);
        issue(encode_imm(12'd10, rd, rv_core_pkg::FUNCT3_SLL, rd), 1'b1);
        issue(encode_imm({2'b0, value[9:0]}, rd, rv_core_pkg::FUNCT3_OR, rd), 1'b1);
    endtask

    task automatic test_op_imm();
        load_reg(5'd1, 32'h8765_4321);
        load_reg(5'd2, 32'h0000_0009);
        issue(encode_imm(12'hff6, 5'd1, rv_core_pkg::FUNCT3_ADD, 5'd10), 1'b1);   // -10
        issue(encode_imm(12'hfff, 5'd1, rv_core_pkg::FUNCT3_SLT, 5'd11), 1'b1);
        issue(encode_imm(12'h800, 5'd2, rv_core_pkg::FUNCT3_SLT, 5'd12), 1'b1);
        issue(encode_imm(12'hfff, 5'd2, rv_core_pkg::FUNCT3_SLTU, 5'd13), 1'b1);  // vs all ones
        issue(encode_imm(12'ha5a, 5'd1, rv_core_pkg::FUNCT3_XOR, 5'd14), 1'b1);
        issue(encode_imm(12'hff0, 5'd2, rv_core_pkg::FUNCT3_OR, 5'd15), 1'b1);
        issue(encode_imm(12'h7f0, 5'd1, rv_core_pkg::FUNCT3_AND, 5'd16), 1'b1);
        issue(encode_imm(12'd7, 5'd1, rv_core_pkg::FUNCT3_SLL, 5'd17), 1'b1);
        issue(encode_imm(12'd13, 5'd1, rv_core_pkg::FUNCT3_SR, 5'd18), 1'b1);
        issue(encode_imm(12'h40d, 5'd1, rv_core_pkg::FUNCT3_SR, 5'd19), 1'b1);    // srai 13
        issue(encode_imm(12'h001, 5'd12, rv_core_pkg::FUNCT3_ADD, 5'd20), 1'b1);
        check_reg(5'd1);
        check_reg(5'd2);
        for (int i = 10; i <= 20; i++) begin
            check_reg(5'(i));
        end
    endtask

    task automatic test_op();
        load_reg(5'd1, 32'h8000_0005);  // negative
        load_reg(5'd2, 32'h0000_0007);
        load_reg(5'd3, 32'hffff_ff83);  // shift amount 3 in the low bits
        issue(encode_reg(7'h00, 5'd2, 5'd1, rv_core_pkg::FUNCT3_ADD, 5'd10), 1'b1);
        issue(encode_reg(7'h20, 5'd2, 5'd1, rv_core_pkg::FUNCT3_ADD, 5'd11), 1'b1);
        issue(encode_reg(7'h00, 5'd3, 5'd1, rv_core_pkg::FUNCT3_SLL, 5'd12), 1'b1);
        issue(encode_reg(7'h00, 5'd2, 5'd1, rv_core_pkg::FUNCT3_SLT, 5'd13), 1'b1);
        issue(encode_reg(7'h00, 5'd1, 5'd2, rv_core_pkg::FUNCT3_SLT, 5'd14), 1'b1);
        issue(encode_reg(7'h00, 5'd2, 5'd1, rv_core_pkg::FUNCT3_SLTU, 5'd15), 1'b1);
        issue(encode_reg(7'h00, 5'd1, 5'd2, rv_core_pkg::FUNCT3_SLTU, 5'd16), 1'b1);
        issue(encode_reg(7'h00, 5'd3, 5'd1, rv_core_pkg::FUNCT3_XOR, 5'd17), 1'b1);
        issue(encode_reg(7'h00, 5'd2, 5'd1, rv_core_pkg::FUNCT3_SR, 5'd18), 1'b1);
        issue(encode_reg(7'h20, 5'd2, 5'd1, rv_core_pkg::FUNCT3_SR, 5'd19), 1'b1);
        issue(encode_reg(7'h00, 5'd3, 5'd2, rv_core_pkg::FUNCT3_OR, 5'd20), 1'b1);
        issue(encode_reg(7'h00, 5'd3, 5'd1, rv_core_pkg::FUNCT3_AND, 5'd21), 1'b1);
        for (int i = 10; i <= 21; i++) begin
            check_reg(5'(i));
        end
    endtask

    // every instruction reads the rd of the one just before it
    task automatic test_forwarding();
        issue(encode_imm(12'd3, 5'd0, rv_core_pkg::FUNCT3_ADD, 5'd5), 1'b1);
        issue(encode_reg(7'h00, 5'd5, 5'd5, rv_core_pkg::FUNCT3_ADD, 5'd6), 1'b1);
        issue(encode_reg(7'h20, 5'd6, 5'd0, rv_core_pkg::FUNCT3_ADD, 5'd7), 1'b1);
        issue(encode_reg(7'h00, 5'd5, 5'd7, rv_core_pkg::FUNCT3_SLL, 5'd8), 1'b1);
        issue(encode_imm(12'h555, 5'd8, rv_core_pkg::FUNCT3_XOR, 5'd9), 1'b1);
        issue(encode_reg(7'h20, 5'd9, 5'd8, rv_core_pkg::FUNCT3_SR, 5'd10), 1'b1);
        for (int i = 5; i <= 10; i++) begin
            check_reg(5'(i));
        end
    endtask

    task automatic test_zero_reg();
        issue(encode_imm(12'h123, 5'd0, rv_core_pkg::FUNCT3_ADD, 5'd0), 1'b1);
        issue(encode_reg(7'h00, 5'd0, 5'd0, rv_core_pkg::FUNCT3_ADD, 5'd3), 1'b1);  // x0 in wb
        issue(encode_imm(12'hfff, 5'd1, rv_core_pkg::FUNCT3_ADD, 5'd0), 1'b1);
        issue(encode_imm(12'h00f, 5'd0, rv_core_pkg::FUNCT3_OR, 5'd4), 1'b1);
        issue(encode_reg(7'h20, 5'd0, 5'd4, rv_core_pkg::FUNCT3_ADD, 5'd5), 1'b1);
        for (int i = 0; i <= 5; i++) begin
            check_reg(5'(i));
        end
    endtask

    task automatic test_errors();
        rv_core_pkg::word_t data;
        logic               err;
        issue({20'h12345, 5'd6, 7'b011_0111}, 1'b0);                                 // lui
        issue(encode_reg(7'h01, 5'd2, 5'd1, rv_core_pkg::FUNCT3_ADD, 5'd6), 1'b0);  // mul
        issue(encode_reg(7'h20, 5'd2, 5'd1, rv_core_pkg::FUNCT3_SLT, 5'd6), 1'b0);
        issue(encode_imm(12'h405, 5'd1, rv_core_pkg::FUNCT3_SLL, 5'd6), 1'b0);
        apb_write(12'h040, 32'hdead_beef, err);            // unmapped
        check_err(err, 1'b1);
        apb_write(rv_core_pkg::REG_BASE_ADDR + 12'd24, 32'hdead_beef, err);  // x6 is read only
        check_err(err, 1'b1);
        apb_read(12'h7f0, data, err);
        check_err(err, 1'b0);
        assert (data == '0) else begin
            data_errors++;
            $display("error %0t: prdata for unmapped read is %h, expected 0", $time, data);
        end
        check_all_regs();
    endtask

    task automatic test_random();
        rv_core_pkg::reg_idx_t rd;
        rv_core_pkg::reg_idx_t rs1;
        rv_core_pkg::reg_idx_t rs2;
        logic [11:0]           imm;
        for (int n = 0; n < 60; n++) begin
            rd  = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            imm = 12'(rand_bits(12));
            if (rand_bits(1) == 32'd1) begin
                issue(encode_reg(7'h00, rs2, rs1, rv_core_pkg::FUNCT3_ADD, rd), 1'b1);
            end else begin
                issue(encode_imm(imm, rs1, rv_core_pkg::FUNCT3_ADD, rd), 1'b1);
            end
        end
        check_all_regs();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        apb_req         = '0;
        reset           = 1'b1;
        lfsr            = LFSR_SEED;
        data_errors     = 0;
        response_errors = 0;
        for (int i = 0; i < rv_core_pkg::REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_all_regs();  // all zero after reset
        test_op_imm();
        test_op();
        test_forwarding();
        test_zero_reg();
        test_errors();
        test_random();
        $display("errors: %0d register values, %0d pslverr responses",
                 data_errors, response_errors);
        if (data_errors + response_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
